// File: bus_pkg.sv
// local bus types: byte address and data byte
// plus the size of the address space for range checks
package bus_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 8;

    // byte address on the local bus
    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    // one data byte per bus write
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // one past the last byte address, needs the extra bit
    localparam logic [BUS_ADDR_W:0] BUS_ADDR_SPAN = {1'b1, {BUS_ADDR_W{1'b0}}};

endpackage

// File: tcp_pkg.sv
// tcp receive stream types, frame header constants
// and the states of the frame parser
package tcp_pkg;

    localparam int TCP_BYTE_W = 8;
    localparam int TCP_LEN_W  = 16;

    typedef logic [TCP_BYTE_W-1:0] tcp_byte_t;  // one byte from the rx fifo
    typedef logic [TCP_LEN_W-1:0]  tcp_len_t;   // payload length field
    typedef logic [15:0]           tcp_wc_t;    // rx fifo write count

    // header is 2 length bytes then 4 address bytes, both low byte first
    localparam int HDR_BYTES = 6;

    // header plus payload must still fit a 16 bit byte count
    localparam tcp_len_t MAX_LEN = tcp_len_t'(16'hffff - HDR_BYTES);

    typedef enum logic [2:0] {
        ST_LEN_LO,
        ST_LEN_HI,
        ST_ADD0,
        ST_ADD1,
        ST_ADD2,
        ST_ADD3,
        ST_DATA,    // payload bytes, one bus write each
        ST_INVALID  // locked until a reset run
    } parse_state_t;

endpackage

// File: tcp_to_bus.sv
// tcp rx stream frame parser: header decode, length and range checks,
// 0xff reset-run detection, rx write count and bus write generation
`timescale 1ns/1ps

module tcp_to_bus #(
    parameter int RESET_RUN = 65535
) (
    input  logic               BUS_CLK,
    input  logic               BUS_RST,
    input  logic               tcp_rx_wr,
    input  tcp_pkg::tcp_byte_t tcp_rx_data,
    output tcp_pkg::tcp_wc_t   tcp_rx_wc,
    output logic               bus_wr,
    output bus_pkg::bus_addr_t bus_add,
    output bus_pkg::bus_data_t bus_data,
    output logic               invalid
);

    localparam int CNT_W = (RESET_RUN > 1) ? $clog2(RESET_RUN) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_RUN - 1);

    tcp_pkg::parse_state_t state;
    tcp_pkg::tcp_len_t     length;     // payload length from the header
    tcp_pkg::tcp_len_t     remain;     // payload bytes still expected
    logic [CNT_W-1:0]      ff_cnt;     // 0xff bytes seen in a row
    logic                  is_ff;
    logic                  tcp_reset;
    logic                  len_bad;
    logic                  range_bad;
    logic [32:0]           frame_end;

    // consecutive strobes only, an idle cycle restarts from zero
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            tcp_rx_wc <= '0;
        end else if (tcp_rx_wr) begin
            tcp_rx_wc <= tcp_rx_wc + 1'b1;
        end else begin
            tcp_rx_wc <= '0;
        end
    end

    assign is_ff = (tcp_rx_data == 8'hff);

    // saturates at the last count so every further 0xff keeps resetting
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ff_cnt <= '0;
        end else if (tcp_rx_wr) begin
            if (!is_ff) begin
                ff_cnt <= '0;
            end else if (ff_cnt != CNT_LAST) begin
                ff_cnt <= ff_cnt + 1'b1;
            end
        end
    end

    assign tcp_reset = tcp_rx_wr && is_ff && (ff_cnt == CNT_LAST);

    // header checks on the byte that completes each field
    assign len_bad   = ({tcp_rx_data, length[7:0]} > tcp_pkg::MAX_LEN);
    assign frame_end = {1'b0, tcp_rx_data, bus_add[23:0]} + 33'(length);
    assign range_bad = (frame_end > bus_pkg::BUS_ADDR_SPAN);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state <= tcp_pkg::ST_LEN_LO;
        end else if (tcp_reset) begin
            state <= tcp_pkg::ST_LEN_LO;  // reset run wins in every state
        end else if (tcp_rx_wr) begin
            case (state)
                tcp_pkg::ST_LEN_LO: state <= tcp_pkg::ST_LEN_HI;
                tcp_pkg::ST_LEN_HI: state <= len_bad ? tcp_pkg::ST_INVALID : tcp_pkg::ST_ADD0;
                tcp_pkg::ST_ADD0:   state <= tcp_pkg::ST_ADD1;
                tcp_pkg::ST_ADD1:   state <= tcp_pkg::ST_ADD2;
                tcp_pkg::ST_ADD2:   state <= tcp_pkg::ST_ADD3;
                tcp_pkg::ST_ADD3: begin
                    if (range_bad) begin
                        state <= tcp_pkg::ST_INVALID;
                    end else if (length == '0) begin
                        state <= tcp_pkg::ST_LEN_LO;  // empty frame ends here
                    end else begin
                        state <= tcp_pkg::ST_DATA;
                    end
                end
                tcp_pkg::ST_DATA: begin
                    if (remain == tcp_pkg::tcp_len_t'(1)) begin
                        state <= tcp_pkg::ST_LEN_LO;
                    end
                end
                default: state <= tcp_pkg::ST_INVALID;  // held until reset run
            endcase
        end
    end

    // length, address and byte count follow the state
    always_ff @(posedge BUS_CLK) begin
        if (tcp_rx_wr) begin
            case (state)
                tcp_pkg::ST_LEN_LO: length[7:0]    <= tcp_rx_data;
                tcp_pkg::ST_LEN_HI: length[15:8]   <= tcp_rx_data;
                tcp_pkg::ST_ADD0:   bus_add[7:0]   <= tcp_rx_data;
                tcp_pkg::ST_ADD1:   bus_add[15:8]  <= tcp_rx_data;
                tcp_pkg::ST_ADD2:   bus_add[23:16] <= tcp_rx_data;
                tcp_pkg::ST_ADD3: begin
                    bus_add[31:24] <= tcp_rx_data;
                    remain         <= length;
                end
                tcp_pkg::ST_DATA: begin
                    bus_add <= bus_add + 1'b1;  // next payload byte address
                    remain  <= remain - 1'b1;
                end
                default: remain <= '0;
            endcase
        end
    end

    assign invalid  = (state == tcp_pkg::ST_INVALID);
    assign bus_wr   = tcp_rx_wr && (state == tcp_pkg::ST_DATA);
    assign bus_data = tcp_rx_data;  // qualified by bus_wr at the slaves

    // every bus write is carried by a received byte that the frame still owes
    a_wr_in_frame: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        bus_wr |-> tcp_rx_wr && (remain != '0));

    // lock-out lasts until the reset run, with no bus write in between
    a_lock_holds: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        invalid && !tcp_reset |=> invalid && !bus_wr);

endmodule

// File: bus_reg_bank.sv
// byte register bank on the local bus with window decode,
// presented as one flat control vector
`timescale 1ns/1ps

module bus_reg_bank #(
    parameter bus_pkg::bus_addr_t REG_BASE  = 32'h0000_0000,
    parameter int                 REG_BYTES = 16
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic                   bus_wr,
    input  bus_pkg::bus_addr_t     bus_add,
    input  bus_pkg::bus_data_t     bus_data,
    output logic [REG_BYTES*8-1:0] ctrl
);

    localparam int IDX_W = (REG_BYTES > 1) ? $clog2(REG_BYTES) : 1;

    bus_pkg::bus_addr_t offset;     // address relative to the bank base
    logic               hit;
    logic [IDX_W-1:0]   idx;
    bus_pkg::bus_data_t regs [REG_BYTES];

    // below base would wrap the offset, so check both ends
    assign offset = bus_add - REG_BASE;
    assign hit    = bus_wr && (bus_add >= REG_BASE) &&
                    (offset < bus_pkg::bus_addr_t'(REG_BYTES));
    assign idx    = offset[IDX_W-1:0];

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            for (int i = 0; i < REG_BYTES; i++) begin
                regs[i] <= '0;
            end
        end else if (hit) begin
            regs[idx] <= bus_data;
        end
    end

    // register i drives ctrl byte i
    always_comb begin
        for (int i = 0; i < REG_BYTES; i++) begin
            ctrl[i*8 +: 8] = regs[i];
        end
    end

    // a decoded write shows up on its own ctrl byte one cycle later
    a_wr_reaches_ctrl: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        hit |=> (ctrl[$past(idx)*8 +: 8] == $past(bus_data)));

endmodule

// File: bus_ram.sv
// byte wide RAM on the local bus: decoded write port from the bus
// and a separate registered readback port
`timescale 1ns/1ps

module bus_ram #(
    parameter bus_pkg::bus_addr_t RAM_BASE  = 32'h0000_1000,
    parameter int                 RAM_BYTES = 1024
) (
    input  logic               BUS_CLK,
    input  logic               bus_wr,
    input  bus_pkg::bus_addr_t bus_add,
    input  bus_pkg::bus_data_t bus_data,
    input  logic               rd_en,
    input  bus_pkg::bus_addr_t rd_add,   // offset within the RAM
    output bus_pkg::bus_data_t rd_data
);

    localparam int AW = (RAM_BYTES > 1) ? $clog2(RAM_BYTES) : 1;

    bus_pkg::bus_data_t mem [RAM_BYTES];
    bus_pkg::bus_addr_t wr_off;
    logic               wr_hit;

    assign wr_off = bus_add - RAM_BASE;
    assign wr_hit = bus_wr && (bus_add >= RAM_BASE) &&
                    (wr_off < bus_pkg::bus_addr_t'(RAM_BYTES));

    always_ff @(posedge BUS_CLK) begin
        if (wr_hit) begin
            mem[wr_off[AW-1:0]] <= bus_data;
        end
    end

    // read before write when both hit the same byte
    always_ff @(posedge BUS_CLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_add[AW-1:0]];
        end
    end

    // readback requests must stay inside the RAM
    a_rd_in_range: assert property (@(posedge BUS_CLK)
        rd_en |-> (rd_add < bus_pkg::bus_addr_t'(RAM_BYTES)));

endmodule

// File: tcp_bus_top.sv
// top level: tcp frame parser driving the local bus
// with the register bank and the RAM as slaves
`timescale 1ns/1ps

module tcp_bus_top #(
    parameter int                 RESET_RUN = 65535,
    parameter bus_pkg::bus_addr_t REG_BASE  = 32'h0000_0000,
    parameter int                 REG_BYTES = 16,
    parameter bus_pkg::bus_addr_t RAM_BASE  = 32'h0000_1000,
    parameter int                 RAM_BYTES = 1024
) (
    input  logic                   BUS_CLK,
    input  logic                   BUS_RST,
    input  logic                   tcp_rx_wr,
    input  tcp_pkg::tcp_byte_t     tcp_rx_data,
    input  bus_pkg::bus_addr_t     rd_add,
    input  logic                   rd_en,
    output tcp_pkg::tcp_wc_t       tcp_rx_wc,
    output logic                   invalid,
    output logic                   bus_wr,
    output bus_pkg::bus_addr_t     bus_add,
    output bus_pkg::bus_data_t     bus_data,
    output logic [REG_BYTES*8-1:0] ctrl,
    output bus_pkg::bus_data_t     rd_data
);

    // parser is the only bus master
    tcp_to_bus #(
        .RESET_RUN(RESET_RUN)
    ) i_tcp_to_bus (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .tcp_rx_wr  (tcp_rx_wr),
        .tcp_rx_data(tcp_rx_data),
        .tcp_rx_wc  (tcp_rx_wc),
        .bus_wr     (bus_wr),
        .bus_add    (bus_add),
        .bus_data   (bus_data),
        .invalid    (invalid)
    );

    bus_reg_bank #(
        .REG_BASE (REG_BASE),
        .REG_BYTES(REG_BYTES)
    ) i_bus_reg_bank (
        .BUS_CLK (BUS_CLK),
        .BUS_RST (BUS_RST),
        .bus_wr  (bus_wr),
        .bus_add (bus_add),
        .bus_data(bus_data),
        .ctrl    (ctrl)
    );

    bus_ram #(
        .RAM_BASE (RAM_BASE),
        .RAM_BYTES(RAM_BYTES)
    ) i_bus_ram (
        .BUS_CLK (BUS_CLK),
        .bus_wr  (bus_wr),
        .bus_add (bus_add),
        .bus_data(bus_data),
        .rd_en   (rd_en),
        .rd_add  (rd_add),
        .rd_data (rd_data)
    );

endmodule

// File: tb_clk_gen.sv
// testbench clock source and synchronous reset pulse
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // reset held over the first few rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tcp_bus_tb.sv
// testbench for the tcp stream to bus bridge: lfsr frame stimulus,
// reference parser with shadow registers and RAM, checks and watchdog
`timescale 1ns/1ps

module tcp_bus_tb;

    localparam int                 CLK_PERIOD = 10;
    localparam int                 RST_CYCLES = 5;
    localparam int                 RESET_RUN  = 16;
    localparam bus_pkg::bus_addr_t REG_BASE   = 32'h0000_0000;
    localparam int                 REG_BYTES  = 16;
    localparam bus_pkg::bus_addr_t RAM_BASE   = 32'h0000_1000;
    localparam int                 RAM_BYTES  = 1024;
    localparam int                 TB_MAX_LEN = 65529;    // largest legal payload
    localparam int                 N_FRAMES   = 80;
    localparam int                 MAX_GAP    = 4;        // idle cycles before a byte
    localparam int                 MAX_FRAME  = 6 + 40;   // header plus longest payload
    localparam int                 MAX_CYCLES = RST_CYCLES + 2 * RAM_BYTES + 200 +
                                                2 * N_FRAMES * MAX_FRAME * (1 + MAX_GAP);
    localparam int                 CHK_W      = (REG_BYTES * 8 > 32) ? REG_BYTES * 8 : 32;
    localparam int                 PH_DATA    = 6;        // phases 0..5 are header bytes
    localparam int                 PH_LOCKED  = 7;

    logic                   bus_clk;
    logic                   bus_rst;
    logic                   tcp_rx_wr;
    tcp_pkg::tcp_byte_t     tcp_rx_data;
    bus_pkg::bus_addr_t     rd_add;
    logic                   rd_en;
    tcp_pkg::tcp_wc_t       tcp_rx_wc;
    logic                   invalid;
    logic                   bus_wr;
    bus_pkg::bus_addr_t     bus_add;
    bus_pkg::bus_data_t     bus_data;
    logic [REG_BYTES*8-1:0] ctrl;
    bus_pkg::bus_data_t     rd_data;

    logic [31:0] lfsr_state;
    int          n_checks;
    int          n_errors;
    int          n_frames;
    int          n_bad_frames;

    // reference model state, registered values as seen before the current cycle
    int          m_phase;
    logic [15:0] m_len;
    logic [31:0] m_addr;       // address of the next payload byte
    logic [15:0] m_left;
    int          m_ff_run;
    logic [15:0] m_wc;
    logic [7:0]  m_regs [REG_BYTES];
    logic [7:0]  m_ram [RAM_BYTES];
    bit          rd_pending;
    logic [7:0]  rd_exp;

    tb_clk_gen #(
        .PERIOD_NS (CLK_PERIOD),
        .RST_CYCLES(RST_CYCLES)
    ) i_clk_gen (
        .clk(bus_clk),
        .rst(bus_rst)
    );

    tcp_bus_top #(
        .RESET_RUN(RESET_RUN),
        .REG_BASE (REG_BASE),
        .REG_BYTES(REG_BYTES),
        .RAM_BASE (RAM_BASE),
        .RAM_BYTES(RAM_BYTES)
    ) uut (
        .BUS_CLK    (bus_clk),
        .BUS_RST    (bus_rst),
        .tcp_rx_wr  (tcp_rx_wr),
        .tcp_rx_data(tcp_rx_data),
        .rd_add     (rd_add),
        .rd_en      (rd_en),
        .tcp_rx_wc  (tcp_rx_wc),
        .invalid    (invalid),
        .bus_wr     (bus_wr),
        .bus_add    (bus_add),
        .bus_data   (bus_data),
        .ctrl       (ctrl),
        .rd_data    (rd_data)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [CHK_W-1:0] got,
                               input logic [CHK_W-1:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // slave decode as seen from the bus, writes outside both windows vanish
    task automatic write_slaves(input logic [31:0] addr, input logic [7:0] data);
        logic [31:0] off;
        off = addr - REG_BASE;
        if (addr >= REG_BASE && off < REG_BYTES) begin
            m_regs[off] = data;
        end
        off = addr - RAM_BASE;
        if (addr >= RAM_BASE && off < RAM_BYTES) begin
            m_ram[off] = data;
        end
    endtask

    // advance the reference parser by one cycle
    task automatic model_step(input logic wr, input logic [7:0] data);
        logic [32:0] end_addr;
        if (!wr) begin
            m_wc = '0;   // idle cycle restarts the write count
        end else begin
            m_wc     = m_wc + 1'b1;
            m_ff_run = (data == 8'hff) ? m_ff_run + 1 : 0;
            if (m_phase == PH_DATA) begin
                write_slaves(m_addr, data);
            end
            if (m_ff_run >= RESET_RUN) begin
                m_phase = 0;
            end else begin
                case (m_phase)
                    0: begin
                        m_len[7:0] = data;
                        m_phase    = 1;
                    end
                    1: begin
                        m_len[15:8] = data;
                        m_phase     = (m_len > TB_MAX_LEN) ? PH_LOCKED : 2;
                    end
                    2, 3, 4: begin
                        m_addr[8*(m_phase-2) +: 8] = data;
                        m_phase++;
                    end
                    5: begin
                        m_addr[31:24] = data;
                        end_addr      = {1'b0, m_addr} + 33'(m_len);
                        if (end_addr > 33'h1_0000_0000) begin
                            m_phase = PH_LOCKED;
                        end else if (m_len == 0) begin
                            m_phase = 0;
                        end else begin
                            m_left  = m_len;
                            m_phase = PH_DATA;
                        end
                    end
                    PH_DATA: begin
                        m_addr = m_addr + 1;
                        m_left = m_left - 1;
                        if (m_left == 0) m_phase = 0;
                    end
                    default: ;   // locked, wait for the 0xff run
                endcase
            end
        end
    endtask

    // one clock cycle: drive at the rising edge, compare at the falling edge
    task automatic drive_cycle(input logic wr, input logic [7:0] data,
                               input logic rd, input logic [9:0] raddr);
        logic [REG_BYTES*8-1:0] exp_ctrl;
        logic                   exp_wr;
        @(posedge bus_clk);
        tcp_rx_wr   <= wr;
        tcp_rx_data <= data;
        rd_en       <= rd;
        rd_add      <= 32'(raddr);
        @(negedge bus_clk);
        if (rd_pending) check_value("rd_data", rd_data, rd_exp);
        for (int i = 0; i < REG_BYTES; i++) begin
            exp_ctrl[i*8 +: 8] = m_regs[i];
        end
        exp_wr = wr && (m_phase == PH_DATA);
        check_value("bus_wr", bus_wr, exp_wr);
        if (exp_wr) begin
            check_value("bus_add", bus_add, m_addr);
            check_value("bus_data", bus_data, data);
        end
        check_value("invalid", invalid, m_phase == PH_LOCKED);
        check_value("tcp_rx_wc", tcp_rx_wc, m_wc);
        check_value("ctrl", ctrl, exp_ctrl);
        rd_pending = rd;
        rd_exp     = m_ram[raddr];   // read sees the RAM before this cycle's write
        model_step(wr, data);
    endtask

    // one frame over the whole RAM, each byte a fold of its full address
    task automatic fill_ram();
        logic [15:0] len;
        logic [31:0] addr;
        len  = 16'(RAM_BYTES);
        addr = RAM_BASE;
        drive_cycle(1'b1, len[7:0], 1'b0, '0);
        drive_cycle(1'b1, len[15:8], 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, addr[8*i +: 8], 1'b0, '0);
        end
        for (int i = 0; i < RAM_BYTES; i++) begin
            addr = RAM_BASE + i;
            drive_cycle(1'b1, addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24],
                        1'b0, '0);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = (take_bits(2) == 0) ? 1 + int'(take_bits(2)) : 0;
        repeat (gap) drive_cycle(1'b0, 8'h00, 1'b0, '0);
        drive_cycle(1'b1, b, 1'b0, '0);
    endtask

    task automatic send_frame(input logic [1:0] kind);
        logic [15:0] len;
        logic [31:0] addr;
        logic [7:0]  b;
        int          junk;
        len = 16'(take_bits(6) % 41);
        case (kind)
            2'd0: addr = REG_BASE + take_bits(4);
            2'd1: addr = RAM_BASE + take_bits(10);
            2'd2: addr = 32'h8000_0000 + take_bits(12);   // unmapped
            default: begin
                if (take_bits(1)) begin
                    len  = 16'(TB_MAX_LEN + 1 + take_bits(2));
                    addr = RAM_BASE;
                end else begin
                    len  = 16'(9 + take_bits(5));   // runs past the top of the space
                    addr = 32'hffff_fff8;
                end
            end
        endcase
        send_byte(len[7:0]);
        send_byte(len[15:8]);
        for (int i = 0; i < 4; i++) begin
            send_byte(addr[8*i +: 8]);
        end
        if (kind != 2'd3) begin
            for (int i = 0; i < len; i++) begin
                send_byte(8'(take_bits(8)));
            end
        end else begin
            junk = 1 + int'(take_bits(3));
            for (int i = 0; i < junk; i++) begin
                b = 8'(take_bits(8));
                send_byte((b == 8'hff) ? 8'h00 : b);   // keeps the run length exact
            end
            repeat (RESET_RUN) send_byte(8'hff);
            n_bad_frames++;
        end
        n_frames++;
    endtask

    initial begin
        logic [1:0] kind;
        tcp_rx_wr   = 1'b0;
        tcp_rx_data = '0;
        rd_en       = 1'b0;
        rd_add      = '0;
        lfsr_state  = 32'hb3b3_4d9a;
        n_checks     = 0;
        n_errors     = 0;
        n_frames     = 0;
        n_bad_frames = 0;
        m_phase    = 0;
        m_ff_run   = 0;
        m_wc       = '0;
        m_len      = '0;
        m_addr     = '0;
        m_left     = '0;
        rd_pending = 1'b0;
        rd_exp     = '0;
        for (int i = 0; i < REG_BYTES; i++) m_regs[i] = '0;

        @(negedge bus_rst);
        @(negedge bus_clk);
        check_value("bus_wr", bus_wr, 0);
        check_value("invalid", invalid, 0);
        check_value("tcp_rx_wc", tcp_rx_wc, 0);
        check_value("ctrl", ctrl, 0);

        fill_ram();

        for (int f = 0; f < N_FRAMES; f++) begin
            kind = 2'(take_bits(2));
            send_frame(kind);
            if (kind == 2'd3) send_frame(2'd1);   // fresh frame right after the reset run
        end

        // sweep the RAM through the readback port
        for (int a = 0; a < RAM_BYTES; a++) begin
            drive_cycle(1'b0, 8'h00, 1'b1, 10'(a));
        end
        drive_cycle(1'b0, 8'h00, 1'b0, '0);

        $display("checks: %0d, errors: %0d, frames: %0d, invalid frames: %0d",
                 n_checks, n_errors, n_frames, n_bad_frames);
        if (n_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // bound from the longest possible stimulus plus a margin
    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: stimulus did not finish within %0d cycles, checks: %0d, errors: %0d",
                 MAX_CYCLES, n_checks, n_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: flist.f
bus_pkg.sv
tcp_pkg.sv
tcp_to_bus.sv
bus_reg_bank.sv
bus_ram.sv
tcp_bus_top.sv
tb_clk_gen.sv
tcp_bus_tb.sv
